// File: verilog/fetch_pkg.sv
/*
 * Shared types of the instruction-fetch side
 * Addresses, memory handshake records, block union and fetch packet
 */
package fetch_pkg;

    ////////////////////////////////////////
    // Address space
    ////////////////////////////////////////

    localparam int MEM_ADDR_BITS     = 16;   // 64 KB reach memory
    localparam int BLOCK_OFFSET_BITS = 3;    // 8 bytes per block

    typedef logic [31:0] addr_t;             // Byte address
    typedef logic [MEM_ADDR_BITS-BLOCK_OFFSET_BITS-1:0] block_addr_t;  // Bits 15..3
    typedef logic [31:0] insn_t;

    ////////////////////////////////////////
    // Memory handshake
    ////////////////////////////////////////

    // Transaction tag, zero means nothing pending
    typedef logic [3:0] mem_tag_t;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_command_e;

    // One memory block, seen whole or as two instructions
    typedef union packed {
        logic [63:0]  block;                 // Whole 64-bit word
        insn_t [1:0]  insn;                  // Element 0 at the lower address
    } mem_block_u;

    typedef struct packed {
        logic         valid;                 // Request present this cycle
        mem_command_e command;
        addr_t        addr;                  // Block aligned for loads
        mem_block_u   data;                  // Store payload
    } mem_req_t;

    typedef struct packed {
        mem_tag_t   transaction_tag;         // Same cycle answer to a load
        mem_block_u data;
        mem_tag_t   data_tag;                // Tag of the load this data belongs to
    } mem_resp_t;

    ////////////////////////////////////////
    // Fetch output
    ////////////////////////////////////////

    typedef struct packed {
        logic  valid;
        addr_t pc;
        insn_t insn;
    } fetch_packet_t;

    // Block number of a byte address, upper bits dropped
    function automatic block_addr_t block_of(input addr_t addr);
        return addr[MEM_ADDR_BITS-1:BLOCK_OFFSET_BITS];
    endfunction

endpackage

// File: verilog/fetch_unit.sv
/*
 * Fetch unit with program counter, redirect and stall handling
 * Selects one instruction out of the cached block
 */
`timescale 1ns/1ps

module fetch_unit
    import fetch_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  addr_t         reset_pc,
    input  addr_t         redirect_target,
    input  logic          redirect,
    input  logic          stall,
    output addr_t         fetch_addr,
    output logic          fetch_valid,
    input  mem_block_u    cache_block,
    input  logic          cache_hit,
    output fetch_packet_t packet
);

    ////////////////////////////////////////
    // Program counter
    ////////////////////////////////////////

    addr_t pc;
    addr_t next_pc;
    logic  running;      // Low in the first cycle after reset
    logic  advance;

    // Word select inside the 8-byte block
    logic  word_sel;

    assign fetch_addr  = pc;
    assign fetch_valid = running;       // Lookup is meaningful only once running
    assign word_sel    = pc[2];

    // Packet is formed in the same cycle as the lookup
    always_comb begin
        packet.valid = cache_hit && !redirect;        // Redirect kills the current fetch
        packet.pc    = pc;
        packet.insn  = cache_block.insn[word_sel];    // Upper word when pc[2] set
    end

    // Step only when an instruction actually leaves
    assign advance = packet.valid && !stall;

    always_comb begin
        if (redirect) begin
            next_pc = redirect_target;    // Redirect beats stall and miss
        end else if (advance) begin
            next_pc = pc + 32'd4;
        end else begin
            next_pc = pc;                 // Stall or miss holds the pc
        end
    end

    ////////////////////////////////////////
    // Registers
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            pc      <= reset_pc;
            running <= 1'b0;
        end else begin
            pc      <= next_pc;
            running <= 1'b1;
        end
    end

endmodule

// File: verilog/icache.sv
/*
 * Direct-mapped blocking instruction cache
 * One memory load in flight at a time, abandoned when the fetch address moves
 */
`timescale 1ns/1ps

module icache
    import fetch_pkg::*;
#(
    parameter int CACHE_LINES = 32
) (
    input  logic       clock,
    input  logic       reset,
    input  addr_t      fetch_addr,
    input  logic       fetch_valid,
    input  mem_resp_t  mem_resp,
    output mem_req_t   mem_req,
    output mem_block_u cache_block,
    output logic       cache_hit
);

    localparam int INDEX_BITS = $clog2(CACHE_LINES);
    localparam int TAG_BITS   = $bits(block_addr_t) - INDEX_BITS;

    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [TAG_BITS-1:0]   cache_tag_t;  // Cache tag, unrelated to memory tags

    typedef struct packed {
        mem_block_u data;
        cache_tag_t tag;
    } line_t;

    ////////////////////////////////////////
    // Line storage
    ////////////////////////////////////////

    line_t                  lines [CACHE_LINES];  // Data and tag per line
    logic [CACHE_LINES-1:0] line_valid;           // Cleared by reset

    block_addr_t fetch_block;
    index_t      current_index;
    index_t      last_index;
    cache_tag_t  current_tag;
    cache_tag_t  last_tag;
    logic        line_match;

    assign fetch_block                  = block_of(fetch_addr);
    assign {current_tag, current_index} = fetch_block;

    // Hit is purely combinational on the current address
    assign line_match  = line_valid[current_index] && (lines[current_index].tag == current_tag);
    assign cache_hit   = fetch_valid && line_match;
    assign cache_block = lines[current_index].data;

    ////////////////////////////////////////
    // Miss tracking
    ////////////////////////////////////////

    mem_tag_t current_mem_tag;    // Memory tag we may be waiting on
    logic     miss_outstanding;   // Load not yet accepted by memory
    logic     primed;             // Low until the first address has been seen
    logic     changed_addr;
    logic     got_mem_data;
    logic     update_mem_tag;
    logic     unanswered_miss;
    logic     issue_load;

    // New block requested, or first cycle out of reset
    assign changed_addr = !primed || (current_index != last_index) || (current_tag != last_tag);

    // Data for our own load, a zero tag never matches
    assign got_mem_data = (current_mem_tag != '0) && (mem_resp.data_tag == current_mem_tag);

    // Drop the old tag on a move, keep sampling while unaccepted, clear after fill
    assign update_mem_tag = changed_addr || miss_outstanding || got_mem_data;

    always_comb begin
        if (changed_addr) begin
            unanswered_miss = !line_match;                   // Fresh miss starts next cycle
        end else begin
            unanswered_miss = miss_outstanding && (mem_resp.transaction_tag == '0);
        end
    end

    // Retry the load every cycle until memory hands out a tag
    assign issue_load = miss_outstanding && !changed_addr;

    always_comb begin
        mem_req.valid   = issue_load;
        mem_req.command = issue_load ? MEM_LOAD : MEM_NONE;
        mem_req.addr    = {fetch_addr[31:BLOCK_OFFSET_BITS], {BLOCK_OFFSET_BITS{1'b0}}};
        mem_req.data    = '0;                                // Cache never stores
    end

    ////////////////////////////////////////
    // State registers
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            primed           <= 1'b0;
            last_index       <= '0;
            last_tag         <= '0;
            current_mem_tag  <= '0;
            miss_outstanding <= 1'b0;
            line_valid       <= '0;
        end else begin
            primed           <= 1'b1;
            last_index       <= current_index;
            last_tag         <= current_tag;
            miss_outstanding <= unanswered_miss;
            if (update_mem_tag) begin
                current_mem_tag <= mem_resp.transaction_tag;  // Zero unless a load was taken
            end
            if (got_mem_data) begin
                line_valid[last_index] <= 1'b1;
            end
        end
    end

    // Fill goes to the block the load was issued for
    // which is last_index even if the address moves this very cycle
    always_ff @(posedge clock) begin
        if (got_mem_data) begin
            lines[last_index].data <= mem_resp.data;
            lines[last_index].tag  <= last_tag;
        end
    end

endmodule

// File: verilog/tagged_memory.sv
/*
 * Tagged main memory with fixed load latency
 * Stores win arbitration over loads, up to fifteen loads in flight
 */
`timescale 1ns/1ps

module tagged_memory
    import fetch_pkg::*;
#(
    parameter int MEM_LATENCY = 6
) (
    input  logic      clock,
    input  logic      reset,
    input  mem_req_t  load_req,
    input  mem_req_t  store_req,
    output mem_resp_t mem_resp
);

    localparam int       BLOCKS    = 2 ** (MEM_ADDR_BITS - BLOCK_OFFSET_BITS);
    localparam mem_tag_t FIRST_TAG = mem_tag_t'(1);
    localparam mem_tag_t LAST_TAG  = '1;

    ////////////////////////////////////////
    // Storage and arbitration
    ////////////////////////////////////////

    mem_block_u memory [BLOCKS];      // 64 KB, contents survive reset

    logic store_go;
    logic load_go;

    assign store_go = store_req.valid && (store_req.command == MEM_STORE);
    // One command per cycle, a store always goes first
    assign load_go  = load_req.valid && (load_req.command == MEM_LOAD) && !store_go;

    ////////////////////////////////////////
    // Tag allocation
    ////////////////////////////////////////

    mem_tag_t next_tag;               // Runs 1..15 and skips zero

    always_ff @(posedge clock) begin
        if (reset) begin
            next_tag <= FIRST_TAG;
        end else if (load_go) begin
            if (next_tag == LAST_TAG) begin
                next_tag <= FIRST_TAG;
            end else begin
                next_tag <= next_tag + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Latency pipeline
    ////////////////////////////////////////

    mem_tag_t    pipe_tag  [MEM_LATENCY];    // Zero in a stage means bubble
    block_addr_t pipe_addr [MEM_LATENCY];    // Block address riding with the tag

    // Stage 0 is loaded at the accepting edge
    // so the last stage shows up MEM_LATENCY cycles after acceptance
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < MEM_LATENCY; i++) begin
                pipe_tag[i] <= '0;
            end
        end else begin
            pipe_tag[0] <= load_go ? next_tag : '0;
            for (int i = 1; i < MEM_LATENCY; i++) begin
                pipe_tag[i] <= pipe_tag[i-1];
            end
        end
    end

    always_ff @(posedge clock) begin
        pipe_addr[0] <= block_of(load_req.addr);
        for (int i = 1; i < MEM_LATENCY; i++) begin
            pipe_addr[i] <= pipe_addr[i-1];
        end
    end

    // Store lands at the edge where it is accepted
    always_ff @(posedge clock) begin
        if (store_go) begin
            memory[block_of(store_req.addr)] <= store_req.data;
        end
    end

    ////////////////////////////////////////
    // Response
    ////////////////////////////////////////

    mem_tag_t out_tag;

    assign out_tag = pipe_tag[MEM_LATENCY-1];

    always_comb begin
        mem_resp.transaction_tag = load_go ? next_tag : '0;   // Same cycle answer
        mem_resp.data_tag        = out_tag;
        if (out_tag != '0) begin
            mem_resp.data = memory[pipe_addr[MEM_LATENCY-1]];  // Read in the last stage
        end else begin
            mem_resp.data = '0;
        end
    end

endmodule

// File: verilog/fetch_top.sv
/*
 * Fetch side top level
 * Fetch unit, instruction cache and tagged memory
 */
`timescale 1ns/1ps

module fetch_top
    import fetch_pkg::*;
#(
    parameter int CACHE_LINES = 32,
    parameter int MEM_LATENCY = 6
) (
    input  logic          clock,
    input  logic          reset,
    input  addr_t         reset_pc,
    input  addr_t         redirect_target,
    input  logic          redirect,
    input  logic          stall,
    input  mem_req_t      store_req,      // Program load port
    output fetch_packet_t packet,
    output mem_command_e  mem_command     // Cache side command, for observation
);

    addr_t      fetch_addr;
    logic       fetch_valid;
    mem_block_u cache_block;
    logic       cache_hit;
    mem_req_t   load_req;
    mem_resp_t  mem_resp;

    assign mem_command = load_req.command;

    fetch_unit u_fetch_unit (
        .clock          (clock),
        .reset          (reset),
        .reset_pc       (reset_pc),
        .redirect_target(redirect_target),
        .redirect       (redirect),
        .stall          (stall),
        .fetch_addr     (fetch_addr),
        .fetch_valid    (fetch_valid),
        .cache_block    (cache_block),
        .cache_hit      (cache_hit),
        .packet         (packet)
    );

    icache #(.CACHE_LINES(CACHE_LINES)) u_icache (
        .clock      (clock),
        .reset      (reset),
        .fetch_addr (fetch_addr),
        .fetch_valid(fetch_valid),
        .mem_resp   (mem_resp),
        .mem_req    (load_req),
        .cache_block(cache_block),
        .cache_hit  (cache_hit)
    );

    tagged_memory #(.MEM_LATENCY(MEM_LATENCY)) u_memory (
        .clock    (clock),
        .reset    (reset),
        .load_req (load_req),
        .store_req(store_req),
        .mem_resp (mem_resp)
    );

endmodule

// File: bench/fetch_sva.sv
/*
 * Concurrent checks on the fetch top-level ports, bound into fetch_top
 */
`timescale 1ns/1ps

module fetch_sva
    import fetch_pkg::*;
(
    input logic          clock,
    input logic          reset,
    input addr_t         redirect_target,
    input logic          redirect,
    input logic          stall,
    input fetch_packet_t packet,
    input mem_command_e  mem_command
);

    localparam addr_t LOOP_BYTES = 32'd256;   // Exactly 32 lines of 8 bytes

    int unsigned failures = 0;   // Polled by the testbench
    logic        loop_seen;      // Loop walked once from reset
    logic        loop_left;      // Fetch went past the loop since, lines may be gone

    always_ff @(posedge clock) begin
        if (reset) begin
            loop_seen <= 1'b0;
            loop_left <= 1'b0;
        end else begin
            if (packet.valid && !stall && (packet.pc == LOOP_BYTES - 32'd4)) begin
                loop_seen <= 1'b1;
            end
            if ((redirect && (redirect_target >= LOOP_BYTES))
                    || (!redirect && (packet.pc >= LOOP_BYTES))) begin
                loop_left <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Port rules
    ////////////////////////////////////////

    assert property (@(posedge clock) $fell(reset) |-> !packet.valid)
        else begin
            $error("packet valid in the first cycle after reset");
            failures++;
        end

    // Held packet keeps pc, and its word too once it was valid
    assert property (@(posedge clock) disable iff (reset)
        stall && !redirect |=> (packet.pc == $past(packet.pc))
            && (!$past(packet.valid) || (packet.insn == $past(packet.insn))))
        else begin
            $error("packet changed while stall was high");
            failures++;
        end

    // Warm loop never misses
    assert property (@(posedge clock) disable iff (reset)
        loop_seen && !loop_left && !stall && !redirect && (packet.pc < LOOP_BYTES)
            |-> packet.valid)
        else begin
            $error("fetch missed inside the cached loop");
            failures++;
        end

    assert property (@(posedge clock) disable iff (reset)
        (mem_command != MEM_STORE) && (!packet.valid || (mem_command == MEM_NONE)))
        else begin
            $error("cache memory command wrong for this cycle");
            failures++;
        end

endmodule

bind fetch_top fetch_sva u_sva (.*);

// File: bench/fetch_tb.sv
/*
 * Testbench for fetch_top
 * Program load, four fetch phases, packet checks against a reference and a watchdog
 */
`timescale 1ns/1ps

module fetch_tb
    import fetch_pkg::*;
();

    localparam int    CACHE_LINES = 32;
    localparam int    MEM_LATENCY = 6;
    localparam int    PERIOD      = 20;
    localparam int    BLOCKS      = 64;          // 512 bytes of program
    localparam int    REDIRECTS   = 40;
    localparam addr_t LOOP_LAST   = 32'd252;     // Last word of the 256-byte loop
    localparam int    FETCHES     = 3 * 64 + REDIRECTS * 8;
    localparam int    WATCHDOG_NS = (FETCHES * (MEM_LATENCY + 20) + BLOCKS + 4) * PERIOD;

    logic          clock;
    logic          reset;
    addr_t         reset_pc;
    addr_t         redirect_target;
    logic          redirect;
    logic          stall;
    mem_req_t      store_req;
    fetch_packet_t packet;
    mem_command_e  mem_command;

    logic [63:0] ref_blocks [BLOCKS];   // Mirror of every store
    logic [31:0] lcg_state   = 32'd85;
    addr_t       expected_pc = '0;      // Pc of the next valid packet

    fetch_top #(.CACHE_LINES(CACHE_LINES), .MEM_LATENCY(MEM_LATENCY)) DUT (.*);

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        fail_run($sformatf("MISMATCH at %0t: %s expected %h actual %h",
                           $time, name, expected, actual));
    endtask

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int random_below(input int limit);
        return int'((next_random() >> 16) % limit);   // High bits, low ones cycle fast
    endfunction

    function automatic insn_t reference_insn(input addr_t pc);
        logic [63:0] word;
        word = ref_blocks[pc[8:3]];
        return pc[2] ? word[63:32] : word[31:0];      // Lower word at the lower address
    endfunction

    // Back to back stores, so cache loads lose arbitration meanwhile
    task automatic load_program();
        logic [63:0] word;
        store_req.valid   = 1'b1;
        store_req.command = MEM_STORE;
        for (int i = 0; i < BLOCKS; i++) begin
            word                 = {next_random(), next_random()};
            ref_blocks[i]        = word;
            store_req.addr       = addr_t'(i * 8);
            store_req.data.block = word;
            @(negedge clock);
        end
        store_req = '0;
        stall     = 1'b0;
    endtask

    // Fetch until last_pc leaves, stalling one cycle in stall_odds when nonzero
    task automatic run_until(input addr_t last_pc, input int stall_odds);
        logic done;
        done = 1'b0;
        while (!done) begin
            @(posedge clock);
            done = packet.valid && !stall && (packet.pc == last_pc);
            @(negedge clock);
            stall = (stall_odds != 0) && (random_below(stall_odds) == 0);
        end
        stall = 1'b0;
    endtask

    task automatic take_packets(input int count);
        int taken;
        taken = 0;
        while (taken < count) begin
            @(posedge clock);
            if (packet.valid && !stall) begin
                taken++;
            end
            @(negedge clock);
        end
    endtask

    task automatic redirect_to(input addr_t target);
        redirect        = 1'b1;
        redirect_target = target;
        @(negedge clock);
        redirect        = 1'b0;
    endtask

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    always @(posedge clock) begin
        if (!reset) begin
            if (packet.valid) begin
                assert (packet.pc < BLOCKS * 8)
                    else fail_run("packet pc left the loaded program");
                assert (packet.pc == expected_pc)
                    else report_mismatch("packet.pc", expected_pc, packet.pc);
                assert (packet.insn == reference_insn(packet.pc))
                    else report_mismatch("packet.insn", reference_insn(packet.pc), packet.insn);
                expected_pc = stall ? packet.pc : packet.pc + 32'd4;
            end
            if (redirect) begin
                expected_pc = redirect_target;       // First packet after it starts here
            end
        end
    end

    always @(negedge clock) begin
        if (DUT.u_sva.failures != 0) begin
            fail_run("a bound assertion on the fetch ports failed");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        fail_run("fetch stopped making progress and the watchdog ran out");
    end

    initial begin
        reset           = 1'b1;
        reset_pc        = '0;
        redirect_target = '0;
        redirect        = 1'b0;
        stall           = 1'b1;     // Fetch held while the program goes in
        store_req       = '0;
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        load_program();
        run_until(LOOP_LAST, 0);    // Cold pass
        redirect_to('0);
        run_until(LOOP_LAST, 0);    // Warm pass
        redirect_to('0);
        run_until(LOOP_LAST, 4);    // Stall pulses
        for (int n = 0; n < REDIRECTS; n++) begin
            redirect_to(addr_t'(random_below(120) * 4));
            if (random_below(3) == 0) begin
                repeat (random_below(MEM_LATENCY + 2)) @(negedge clock);  // Next one mid-miss
            end else begin
                take_packets(1 + random_below(8));
            end
        end
        take_packets(1);
        if (DUT.u_sva.failures == 0) begin
            $display("test passed");
            $finish;
        end else begin
            fail_run("bound assertions reported failures");
        end
    end

endmodule

// File: verilog.f
verilog/fetch_pkg.sv
verilog/fetch_unit.sv
verilog/icache.sv
verilog/tagged_memory.sv
verilog/fetch_top.sv
bench/fetch_sva.sv
bench/fetch_tb.sv
